/* clk_sync.f */
+incdir+hw
hw/clk_sync_pkg.sv
hw/calc_result_if.sv
hw/cycle_timer.sv
hw/mailbox_rx.sv
hw/offset_calc.sv
hw/sync_regs.sv
hw/clk_sync_master_top.sv
bench/clk_sync_asserts.sv
bench/clk_sync_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module clk_sync_tb -f clk_sync.f

out=$(./obj_dir/Vclk_sync_tb +verilator+error+limit+10) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

/* bench/clk_sync_tb.sv */
`default_nettype none

module clk_sync_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 4000; // Tests take about 1700 cycles.
	localparam logic [31:0] LFSR_SEED = 32'hb1afd9a0;

	logic clk = 1'b0;
	logic arst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [7:0] rx_addr;
	logic [7:0] rx_data;
	logic rx_we;
	logic snap_tx;
	logic snap_rx;
	logic [3:0] scope_trigger;

	logic [31:0] lfsr = LFSR_SEED;
	logic [15:0] ts [4][4]; // Node, slot.
	logic [15:0] snap_tx_val;
	logic [15:0] snap_rx_val;
	int cycle_cnt = 0;

	always #20 clk = ~clk;

	clk_sync_master_top i_dut (
		.clk_i(clk),
		.arst_n_i(arst_n),
		.paddr_i(paddr),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.rx_addr_i(rx_addr),
		.rx_data_i(rx_data),
		.rx_we_i(rx_we),
		.snap_tx_i(snap_tx),
		.snap_rx_i(snap_rx),
		.scope_trigger_o(scope_trigger)
	);

	always @(negedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (i_dut.i_asserts.fail_cnt != 0) begin
			$display("An assertion in the DUT failed before %0t ns", $time);
			$display("TB FAILED");
			$fatal(1, "assertion failure");
		end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_ts(output logic [15:0] v);
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic logic [15:0] fold_offset(input logic [15:0] raw);
		int s;
		s = int'($signed(raw));
		if (s > 16384)
			s = s - 32768;
		else if (s < -16384)
			s = s + 32768;
		return 16'(s);
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "check mismatch");
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		@(negedge clk);
		paddr = addr;
		pwrite = 1'b1;
		pwdata = data;
		psel = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		#10; // Middle of the low phase.
		err = pslverr;
		check("pready in write access", 32'(pready), 32'd1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge clk);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		#10;
		data = prdata;
		err = pslverr;
		check("pready in read access", 32'(pready), 32'd1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic rx_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		rx_addr = addr;
		rx_data = data;
		rx_we = 1'b1;
	endtask

	// Flag word, then the four timestamps, low byte first.
	task automatic send_node(input int n, input logic [15:0] flags);
		logic [7:0] base;
		base = 8'(32 + 16 * n);
		rx_write(base + 8'd2, flags[7:0]);
		rx_write(base + 8'd3, flags[15:8]);
		for (int s = 0; s < 4; s++) begin
			rx_write(base + 8'(4 + 2 * s), ts[n][s][7:0]);
			rx_write(base + 8'(5 + 2 * s), ts[n][s][15:8]);
		end
		@(negedge clk);
		rx_we = 1'b0;
	endtask

	// Returns just after the calculation count moves on.
	task automatic wait_calc();
		logic [31:0] c0;
		logic [31:0] c;
		logic err;
		apb_read(clk_sync_pkg::REG_COUNT, c0, err);
		c = c0;
		while (c == c0)
			apb_read(clk_sync_pkg::REG_COUNT, c, err);
	endtask

	task automatic pulse_snapshots();
		@(negedge clk);
		snap_tx = 1'b1;
		@(negedge clk);
		snap_tx = 1'b0;
		repeat (3) @(negedge clk);
		snap_rx = 1'b1; // Four clocks after the transmit strobe.
		@(negedge clk);
		snap_rx = 1'b0;
	endtask

	task automatic check_results();
		logic [15:0] t2;
		logic [15:0] t3;
		logic [15:0] exp_dly;
		logic [15:0] exp_ofs;
		logic [31:0] rd;
		logic err;
		for (int n = 0; n < 4; n++) begin
			if (n == 0) begin
				t2 = snap_tx_val;
				t3 = snap_rx_val;
			end else begin
				t2 = ts[n - 1][2];
				t3 = ts[n - 1][3];
			end
			exp_dly = ts[n][0] - ts[n][1] - t2 + t3;
			exp_ofs = fold_offset(ts[n][0] + ts[n][1] - t2 - t3);
			apb_read(clk_sync_pkg::REG_OFFSET0 + 8'(4 * n), rd, err);
			check($sformatf("offset of node %0d", n), rd, {16'h0000, exp_ofs});
			apb_read(clk_sync_pkg::REG_DELAY0 + 8'(4 * n), rd, err);
			check($sformatf("delay of node %0d", n), rd, {16'h0000, exp_dly});
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] rd;
		logic err;
		check("pslverr after reset", 32'(pslverr), 32'd0);
		check("scope trigger after reset", 32'(scope_trigger), 32'd0);
		apb_read(clk_sync_pkg::REG_PERIOD, rd, err);
		check("period after reset", rd, 32'd199);
		check("pslverr on period read", 32'(err), 32'd0);
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status after reset", rd, 32'd0);
		apb_read(clk_sync_pkg::REG_COUNT, rd, err);
		check("count after reset", rd, 32'd0);
	endtask

	task automatic test_period();
		logic [31:0] rd;
		logic [31:0] c0;
		logic [31:0] c1;
		logic err;
		int rise;
		apb_write(clk_sync_pkg::REG_PERIOD, 32'd59, err);
		check("pslverr on period write", 32'(err), 32'd0);
		apb_read(clk_sync_pkg::REG_PERIOD, rd, err);
		check("period read back", rd, 32'd59);
		wait_calc();
		wait_calc(); // New period in force.
		apb_read(clk_sync_pkg::REG_COUNT, c0, err);
		repeat (200) @(negedge clk);
		apb_read(clk_sync_pkg::REG_COUNT, c1, err);
		rise = int'(c1 - c0);
		check("calculations in 200 cycles", 32'(rise >= 2 && rise <= 4), 32'd1);
	endtask

	task automatic test_offsets();
		logic [31:0] rd;
		logic [15:0] gap;
		logic err;
		apb_write(clk_sync_pkg::REG_PERIOD, 32'd199, err);
		wait_calc();
		wait_calc(); // Long cycles from here on.
		pulse_snapshots();
		apb_read(clk_sync_pkg::REG_SNAP_TX, rd, err);
		snap_tx_val = rd[15:0];
		apb_read(clk_sync_pkg::REG_SNAP_RX, rd, err);
		snap_rx_val = rd[15:0];
		gap = snap_rx_val - snap_tx_val;
		check("snapshot spacing", 32'(gap), 32'd4);
		for (int n = 0; n < 4; n++)
			for (int s = 0; s < 4; s++)
				random_ts(ts[n][s]);
		for (int n = 0; n < 4; n++)
			send_node(n, 16'h0003);
		wait_calc();
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status with full chain", rd, 32'h0000_0FFF);
		check_results();
	endtask

	task automatic test_partial_chain();
		logic [31:0] rd;
		logic err;
		wait_calc();
		send_node(0, 16'h0004);
		send_node(2, 16'h0004); // Node 1 missing, chain broken.
		wait_calc();
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status with broken chain", rd, 32'h0000_1001);
		check("scope trigger port", 32'(scope_trigger), 32'd1);
	endtask

	task automatic test_fold();
		logic [31:0] rd;
		logic err;
		ts[0][2] = 16'h0000;
		ts[0][3] = 16'h0000;
		ts[1][0] = 16'h3000;
		ts[1][1] = 16'h3000; // Raw offset +24576.
		ts[1][2] = 16'h3000;
		ts[1][3] = 16'h3000;
		for (int s = 0; s < 4; s++)
			ts[2][s] = 16'h0000; // Raw offset -24576.
		ts[3][0] = 16'h2000;
		ts[3][1] = 16'h2000; // Exactly at the limit.
		wait_calc();
		for (int n = 0; n < 4; n++)
			send_node(n, 16'h0003);
		wait_calc();
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status before fold check", rd, 32'h0000_0FFF);
		check_results();
		apb_read(clk_sync_pkg::REG_OFFSET0 + 8'd4, rd, err);
		check("folded offset above limit", rd, 32'h0000_E000);
		apb_read(clk_sync_pkg::REG_OFFSET0 + 8'd8, rd, err);
		check("folded offset below limit", rd, 32'h0000_2000);
		apb_read(clk_sync_pkg::REG_OFFSET0 + 8'd12, rd, err);
		check("offset at limit", rd, 32'h0000_4000);
	endtask

	task automatic test_bus_errors();
		logic [31:0] rd;
		logic err;
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status before bad write", rd, 32'h0000_0FFF);
		apb_write(clk_sync_pkg::REG_STATUS, 32'h0000_0000, err);
		check("pslverr on status write", 32'(err), 32'd1);
		apb_write(8'h7C, 32'h0000_FFFF, err);
		check("pslverr on unmapped write", 32'(err), 32'd1);
		apb_read(8'h7C, rd, err);
		check("pslverr on unmapped read", 32'(err), 32'd1);
		apb_read(clk_sync_pkg::REG_STATUS, rd, err);
		check("status after bad write", rd, 32'h0000_0FFF);
		apb_read(clk_sync_pkg::REG_PERIOD, rd, err);
		check("period after bad writes", rd, 32'd199);
	endtask

	initial begin
		arst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		rx_addr = '0;
		rx_data = '0;
		rx_we = 1'b0;
		snap_tx = 1'b0;
		snap_rx = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		test_reset_values();
		test_period();
		test_offsets();
		test_partial_chain();
		test_fold();
		test_bus_errors();

		if (i_dut.i_asserts.fail_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "assertion failure at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* bench/clk_sync_asserts.sv */
`default_nettype none

module clk_sync_asserts (
	input wire clk_i,
	input wire arst_n_i,
	input wire cycle_pulse_i,
	input wire pready_i,
	input wire busy_i,
	input wire [2:0] calc_state_i,
	input wire [1:0] calc_node_i
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] LAST_NODE = 2'd3;

	int fail_cnt = 0; // Watched by the testbench.

	pulse_width: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		cycle_pulse_i |=> !cycle_pulse_i)
	else begin
		fail_cnt++;
		$error("cycle pulse held for more than one clock");
	end

	// No wait states on APB.
	no_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i) pready_i)
	else begin
		fail_cnt++;
		$error("pready dropped");
	end

	busy_end: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(busy_i && !(calc_state_i == clk_sync_pkg::S_STORE && calc_node_i == LAST_NODE))
		|=> busy_i)
	else begin
		fail_cnt++;
		$error("busy fell before the last node was stored");
	end

endmodule

bind clk_sync_master_top clk_sync_asserts i_asserts (
	.clk_i(clk_i),
	.arst_n_i(arst_n_i),
	.cycle_pulse_i(cycle_pulse),
	.pready_i(pready_o),
	.busy_i(calc_res.busy),
	.calc_state_i(i_offset_calc.state),
	.calc_node_i(i_offset_calc.node)
);

`default_nettype wire

/* hw/clk_sync_master_top.sv */
`default_nettype none

`include "clk_sync_macros.svh"

module clk_sync_master_top (
	input wire clk_i,
	input wire arst_n_i,
	input wire [`CS_APB_AW-1:0] paddr_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire [`CS_PTR_W-1:0] rx_addr_i,
	input wire [7:0] rx_data_i,
	input wire rx_we_i,
	input wire snap_tx_i,
	input wire snap_rx_i,
	output logic [`CS_NODES-1:0] scope_trigger_o
);

	logic cycle_pulse;
	logic [`CS_TS_W-1:0] snap_tx;
	logic [`CS_TS_W-1:0] snap_rx;
	logic [`CS_TS_W-1:0] period;
	logic [`CS_NODE_W-1:0] rd_node;
	logic [1:0] rd_slot;
	logic [`CS_TS_W-1:0] rd_ts;
	logic [`CS_NODES-1:0] rx_ok;
	logic [`CS_NODES-1:0] sync_ok;
	logic [`CS_NODES-1:0] slave_rdy;

	calc_result_if calc_res ();

	cycle_timer i_cycle_timer (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.period_i(period),
		.snap_tx_i(snap_tx_i),
		.snap_rx_i(snap_rx_i),
		.cycle_pulse_o(cycle_pulse),
		.snap_tx_o(snap_tx),
		.snap_rx_o(snap_rx)
	);

	mailbox_rx i_mailbox_rx (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.rx_addr_i(rx_addr_i),
		.rx_data_i(rx_data_i),
		.rx_we_i(rx_we_i),
		.cycle_pulse_i(cycle_pulse),
		.rd_node_i(rd_node),
		.rd_slot_i(rd_slot),
		.rd_ts_o(rd_ts),
		.rx_ok_o(rx_ok),
		.sync_ok_o(sync_ok),
		.slave_rdy_o(slave_rdy),
		.scope_trigger_o(scope_trigger_o)
	);

	offset_calc i_offset_calc (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.cycle_pulse_i(cycle_pulse),
		.snap_tx_i(snap_tx),
		.snap_rx_i(snap_rx),
		.rd_node_o(rd_node),
		.rd_slot_o(rd_slot),
		.rd_ts_i(rd_ts),
		.res(calc_res)
	);

	sync_regs i_sync_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.period_o(period),
		.snap_tx_i(snap_tx),
		.snap_rx_i(snap_rx),
		.rx_ok_i(rx_ok),
		.sync_ok_i(sync_ok),
		.slave_rdy_i(slave_rdy),
		.scope_trigger_i(scope_trigger_o),
		.res(calc_res)
	);

endmodule

`default_nettype wire

/* hw/sync_regs.sv */
`default_nettype none

`include "clk_sync_macros.svh"

module sync_regs (
	input wire clk_i,
	input wire arst_n_i,
	input wire [`CS_APB_AW-1:0] paddr_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic [`CS_TS_W-1:0] period_o,
	input wire [`CS_TS_W-1:0] snap_tx_i,
	input wire [`CS_TS_W-1:0] snap_rx_i,
	input wire [`CS_NODES-1:0] rx_ok_i,
	input wire [`CS_NODES-1:0] sync_ok_i,
	input wire [`CS_NODES-1:0] slave_rdy_i,
	input wire [`CS_NODES-1:0] scope_trigger_i,
	calc_result_if.regs res
);

	localparam logic [`CS_TS_W-1:0] PERIOD_RST = `CS_PERIOD_RST;

	logic [`CS_TS_W-1:0] offset_r [`CS_NODES];
	logic [`CS_TS_W-1:0] delay_r [`CS_NODES];
	logic [15:0] calc_cnt;
	logic busy_q;
	logic [`CS_APB_AW-1:0] ofs_rel;
	logic [`CS_APB_AW-1:0] dly_rel;
	logic is_ofs;
	logic is_dly;
	logic mapped;
	logic access;

	assign access = psel_i && penable_i;
	assign ofs_rel = paddr_i - clk_sync_pkg::REG_OFFSET0;
	assign dly_rel = paddr_i - clk_sync_pkg::REG_DELAY0;
	assign is_ofs = ofs_rel < 4 * `CS_NODES && paddr_i[1:0] == 2'b00;
	assign is_dly = dly_rel < 4 * `CS_NODES && paddr_i[1:0] == 2'b00;

	always_comb begin
		mapped = 1'b1;
		prdata_o = '0;
		case (paddr_i)
			clk_sync_pkg::REG_PERIOD: prdata_o = 32'(period_o);
			clk_sync_pkg::REG_STATUS:
				prdata_o = 32'({scope_trigger_i, slave_rdy_i, sync_ok_i, rx_ok_i});
			clk_sync_pkg::REG_COUNT: prdata_o = 32'(calc_cnt);
			clk_sync_pkg::REG_SNAP_TX: prdata_o = 32'(snap_tx_i);
			clk_sync_pkg::REG_SNAP_RX: prdata_o = 32'(snap_rx_i);
			default: begin
				if (is_ofs)
					prdata_o = 32'(offset_r[ofs_rel[`CS_NODE_W+1:2]]);
				else if (is_dly)
					prdata_o = 32'(delay_r[dly_rel[`CS_NODE_W+1:2]]);
				else
					mapped = 1'b0;
			end
		endcase
	end

	// Only the period is writable.
	assign pready_o = 1'b1;
	assign pslverr_o = access && (!mapped || (pwrite_i && paddr_i != clk_sync_pkg::REG_PERIOD));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			period_o <= PERIOD_RST;
			calc_cnt <= '0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= res.busy;
			if (busy_q && !res.busy)
				calc_cnt <= calc_cnt + 1'b1; // End of a full pass.
			if (access && pwrite_i && paddr_i == clk_sync_pkg::REG_PERIOD)
				period_o <= pwdata_i[`CS_TS_W-1:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (res.wr) begin
			offset_r[res.node] <= res.offset;
			delay_r[res.node] <= res.delay;
		end
	end

endmodule

`default_nettype wire

/* hw/offset_calc.sv */
`default_nettype none

`include "clk_sync_macros.svh"

module offset_calc (
	input wire clk_i,
	input wire arst_n_i,
	input wire cycle_pulse_i,
	input wire [`CS_TS_W-1:0] snap_tx_i,
	input wire [`CS_TS_W-1:0] snap_rx_i,
	output logic [`CS_NODE_W-1:0] rd_node_o,
	output logic [1:0] rd_slot_o,
	input wire [`CS_TS_W-1:0] rd_ts_i,
	calc_result_if.calc res
);

	localparam int LAST_NODE = `CS_NODES - 1;
	localparam logic [`CS_TS_W-1:0] FOLD_STEP = `CS_FOLD_STEP;

	clk_sync_pkg::calc_state_t state;
	logic [`CS_NODE_W-1:0] node;
	logic [`CS_TS_W-1:0] acc_d;
	logic [`CS_TS_W-1:0] acc_o;
	logic [`CS_TS_W-1:0] snap_tx_q;
	logic [`CS_TS_W-1:0] snap_rx_q;
	logic [`CS_TS_W-1:0] t2;
	logic [`CS_TS_W-1:0] t3;

	// Node 0 talks to the master itself.
	assign t2 = (node == '0) ? snap_tx_q : rd_ts_i;
	assign t3 = (node == '0) ? snap_rx_q : rd_ts_i;

	always_comb begin
		rd_node_o = node;
		rd_slot_o = 2'd0;
		case (state)
			clk_sync_pkg::S_ADD1: rd_slot_o = 2'd1;
			clk_sync_pkg::S_SUB2: begin
				rd_node_o = node - 1'b1; // Previous node in the chain.
				rd_slot_o = 2'd2;
			end
			clk_sync_pkg::S_SUB3: begin
				rd_node_o = node - 1'b1;
				rd_slot_o = 2'd3;
			end
			default: rd_slot_o = 2'd0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= clk_sync_pkg::S_IDLE;
			node <= '0;
		end else begin
			case (state)
				clk_sync_pkg::S_IDLE: begin
					node <= '0;
					if (cycle_pulse_i)
						state <= clk_sync_pkg::S_ADD0;
				end
				clk_sync_pkg::S_ADD0: state <= clk_sync_pkg::S_ADD1;
				clk_sync_pkg::S_ADD1: state <= clk_sync_pkg::S_SUB2;
				clk_sync_pkg::S_SUB2: state <= clk_sync_pkg::S_SUB3;
				clk_sync_pkg::S_SUB3: state <= clk_sync_pkg::S_FOLD;
				clk_sync_pkg::S_FOLD: state <= clk_sync_pkg::S_STORE;
				default: begin
					node <= node + 1'b1;
					if (node == LAST_NODE[`CS_NODE_W-1:0])
						state <= clk_sync_pkg::S_IDLE;
					else
						state <= clk_sync_pkg::S_ADD0;
				end
			endcase
		end
	end

	// delay = t0 - t1 - t2 + t3, offset = t0 + t1 - t2 - t3.
	always_ff @(posedge clk_i) begin
		case (state)
			clk_sync_pkg::S_IDLE: begin
				if (cycle_pulse_i) begin
					snap_tx_q <= snap_tx_i;
					snap_rx_q <= snap_rx_i;
				end
			end
			clk_sync_pkg::S_ADD0: begin
				acc_d <= rd_ts_i;
				acc_o <= rd_ts_i;
			end
			clk_sync_pkg::S_ADD1: begin
				acc_d <= acc_d - rd_ts_i;
				acc_o <= acc_o + rd_ts_i;
			end
			clk_sync_pkg::S_SUB2: begin
				acc_d <= acc_d - t2;
				acc_o <= acc_o - t2;
			end
			clk_sync_pkg::S_SUB3: begin
				acc_d <= acc_d + t3;
				acc_o <= acc_o - t3;
			end
			clk_sync_pkg::S_FOLD: begin
				if ($signed(acc_o) > `CS_FOLD_LIM)
					acc_o <= acc_o - FOLD_STEP;
				else if ($signed(acc_o) < -`CS_FOLD_LIM)
					acc_o <= acc_o + FOLD_STEP;
			end
			default: ;
		endcase
	end

	assign res.wr = state == clk_sync_pkg::S_STORE;
	assign res.node = node;
	assign res.offset = acc_o;
	assign res.delay = acc_d;
	assign res.busy = state != clk_sync_pkg::S_IDLE;

endmodule

`default_nettype wire

/* hw/mailbox_rx.sv */
`default_nettype none

`include "clk_sync_macros.svh"

module mailbox_rx (
	input wire clk_i,
	input wire arst_n_i,
	input wire [`CS_PTR_W-1:0] rx_addr_i,
	input wire [7:0] rx_data_i,
	input wire rx_we_i,
	input wire cycle_pulse_i,
	input wire [`CS_NODE_W-1:0] rd_node_i,
	input wire [1:0] rd_slot_i,
	output logic [`CS_TS_W-1:0] rd_ts_o,
	output logic [`CS_NODES-1:0] rx_ok_o,
	output logic [`CS_NODES-1:0] sync_ok_o,
	output logic [`CS_NODES-1:0] slave_rdy_o,
	output logic [`CS_NODES-1:0] scope_trigger_o
);

	localparam int SLOTS = 4;
	localparam logic [`CS_PTR_W-1:0] HP_BASE = `CS_HP_BASE;
	localparam logic [`CS_PTR_W-1:0] MSG_LEN = `CS_MSG_LEN;
	localparam logic [`CS_PTR_W-1:0] FLAG_OFS = `CS_FLAG_OFS;
	localparam logic [`CS_PTR_W-1:0] TS_OFS = `CS_TS_OFS;

	logic [`CS_PTR_W-1:0] rel;
	logic [`CS_PTR_W-1:0] msg_idx;
	logic [`CS_PTR_W-1:0] byte_ofs;
	logic [`CS_PTR_W-1:0] ts_ofs;
	logic [`CS_NODE_W-1:0] wr_node;
	logic [1:0] wr_slot;
	logic in_area;
	logic ts_write;
	logic ts_lo_we;
	logic ts_hi_we;
	logic flag_lo_we;
	logic flag_hi_we;

	logic [7:0] ts_lo_mem [`CS_NODES*SLOTS];
	logic [7:0] ts_hi_mem [`CS_NODES*SLOTS];
	logic [15:0] flags [`CS_NODES];
	logic [`CS_NODES-1:0] rdy1;
	logic [`CS_NODES-1:0] rdy2;
	logic [`CS_NODES-1:0] chain_ok;
	logic [`CS_NODES-1:0] complete;
	logic [`CS_NODES-1:0] flag0;
	logic [`CS_NODES-1:0] flag1;
	logic [`CS_NODES-1:0] flag2;

	// Receive address decode.
	assign rel = rx_addr_i - HP_BASE;
	assign msg_idx = rel / MSG_LEN;
	assign byte_ofs = rel % MSG_LEN;
	assign ts_ofs = byte_ofs - TS_OFS;
	assign wr_node = msg_idx[`CS_NODE_W-1:0];
	assign wr_slot = ts_ofs[2:1];
	assign in_area = rx_we_i && rx_addr_i >= HP_BASE && msg_idx < `CS_NODES;
	assign ts_write = in_area && byte_ofs >= TS_OFS && byte_ofs < TS_OFS + 2 * SLOTS;
	assign ts_lo_we = ts_write && !ts_ofs[0];
	assign ts_hi_we = ts_write && ts_ofs[0];
	assign flag_lo_we = in_area && byte_ofs == FLAG_OFS;
	assign flag_hi_we = in_area && byte_ofs == FLAG_OFS + 1'b1;

	// Node n only counts once node n-1 is complete.
	assign complete = rdy1 & rdy2;
	assign chain_ok = {complete[`CS_NODES-2:0], 1'b1};

	always_comb begin
		for (int n = 0; n < `CS_NODES; n++) begin
			flag0[n] = flags[n][0];
			flag1[n] = flags[n][1];
			flag2[n] = flags[n][2];
		end
	end

	always_ff @(posedge clk_i) begin
		if (ts_lo_we)
			ts_lo_mem[{wr_node, wr_slot}] <= rx_data_i;
		if (ts_hi_we)
			ts_hi_mem[{wr_node, wr_slot}] <= rx_data_i;
	end

	assign rd_ts_o = {ts_hi_mem[{rd_node_i, rd_slot_i}], ts_lo_mem[{rd_node_i, rd_slot_i}]};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdy1 <= '0;
			rdy2 <= '0;
			for (int n = 0; n < `CS_NODES; n++)
				flags[n] <= '0;
			rx_ok_o <= '0;
			sync_ok_o <= '0;
			slave_rdy_o <= '0;
			scope_trigger_o <= '0;
		end else if (cycle_pulse_i) begin
			rx_ok_o <= complete;
			sync_ok_o <= complete & flag0;
			slave_rdy_o <= complete & flag0 & flag1;
			scope_trigger_o <= complete & flag2;
			rdy1 <= '0;
			rdy2 <= '0;
			for (int n = 0; n < `CS_NODES; n++)
				flags[n] <= '0; // Timestamps stay.
		end else begin
			if (ts_lo_we && chain_ok[wr_node])
				rdy1[wr_node] <= 1'b1;
			if (ts_hi_we && chain_ok[wr_node] && rdy1[wr_node])
				rdy2[wr_node] <= 1'b1;
			if (flag_lo_we)
				flags[wr_node][7:0] <= rx_data_i;
			if (flag_hi_we)
				flags[wr_node][15:8] <= rx_data_i;
		end
	end

endmodule

`default_nettype wire

/* hw/cycle_timer.sv */
`default_nettype none

`include "clk_sync_macros.svh"

module cycle_timer (
	input wire clk_i,
	input wire arst_n_i,
	input wire [`CS_TS_W-1:0] period_i,
	input wire snap_tx_i,
	input wire snap_rx_i,
	output logic cycle_pulse_o,
	output logic [`CS_TS_W-1:0] snap_tx_o,
	output logic [`CS_TS_W-1:0] snap_rx_o
);

	localparam logic [`CS_TS_W-1:0] PERIOD_RST = `CS_PERIOD_RST;

	logic [`CS_TS_W-1:0] cnt;
	logic [`CS_TS_W-1:0] cur_period;
	logic snap_tx_q;
	logic snap_rx_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt <= '0;
			cur_period <= PERIOD_RST;
			cycle_pulse_o <= 1'b0;
			snap_tx_q <= 1'b0;
			snap_rx_q <= 1'b0;
		end else begin
			snap_tx_q <= snap_tx_i;
			snap_rx_q <= snap_rx_i;
			cycle_pulse_o <= 1'b0;
			if (cnt == cur_period) begin
				// Wrap, new period only takes effect here.
				cnt <= '0;
				cur_period <= period_i;
				cycle_pulse_o <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Local time of the last transmit and receive events.
	always_ff @(posedge clk_i) begin
		if (snap_tx_q)
			snap_tx_o <= cnt;
		if (snap_rx_q)
			snap_rx_o <= cnt;
	end

endmodule

`default_nettype wire

/* hw/calc_result_if.sv */
`default_nettype none

`include "clk_sync_macros.svh"

interface calc_result_if;

	logic wr; // One cycle per finished node.
	logic [`CS_NODE_W-1:0] node;
	logic [`CS_TS_W-1:0] offset;
	logic [`CS_TS_W-1:0] delay;
	logic busy; // Whole calculation in progress.

	modport calc (
		output wr,
		output node,
		output offset,
		output delay,
		output busy
	);

	modport regs (
		input wr,
		input node,
		input offset,
		input delay,
		input busy
	);

endinterface

`default_nettype wire

/* hw/clk_sync_pkg.sv */
`default_nettype none

`include "clk_sync_macros.svh"

package clk_sync_pkg;

	// Offset calculator steps, six per node.
	typedef enum logic [2:0] {
		S_IDLE,
		S_ADD0,
		S_ADD1,
		S_SUB2,
		S_SUB3,
		S_FOLD,
		S_STORE
	} calc_state_t;

	typedef enum logic [`CS_APB_AW-1:0] {
		REG_PERIOD  = 8'h00,
		REG_STATUS  = 8'h04,
		REG_COUNT   = 8'h08,
		REG_SNAP_TX = 8'h0C,
		REG_SNAP_RX = 8'h10,
		REG_OFFSET0 = 8'h20, // One word per node.
		REG_DELAY0  = 8'h30  // One word per node.
	} reg_addr_t;

endpackage

`default_nettype wire

/* hw/clk_sync_macros.svh */
`ifndef CLK_SYNC_MACROS_SVH
`define CLK_SYNC_MACROS_SVH

// Ring size.
`define CS_NODES 4
`define CS_NODE_W 2

// Local time and receive bus widths.
`define CS_TS_W 16
`define CS_PTR_W 8

// High-priority mailbox map. The low-priority area sits below CS_HP_BASE.
`define CS_HP_BASE 32
`define CS_MSG_LEN 16
`define CS_FLAG_OFS 2
`define CS_TS_OFS 4

`define CS_PERIOD_RST 199
`define CS_FOLD_LIM 16384
`define CS_FOLD_STEP 32768

`define CS_APB_AW 8

`endif
